//--- daq_stimulus.txt
# command and operand per line: SET <hex time>, BOTH <hex time>, SYNC, WAIT <hex cycles>.
# BOTH loads the time and pulses timesync in the same cycle.
WAIT 120
SET a5c3123456789a10
WAIT 40
SYNC
WAIT 30
BOTH 0000000100000020
WAIT 40
SYNC
WAIT 10
SYNC
WAIT 200
SET 00ffffffffffff08
WAIT 30
SYNC
WAIT 100
BOTH 1122334455667700
WAIT 180
SYNC
WAIT 40

//--- daq_top.f
+incdir+.
daq_pkg.sv
timebase.sv
systime_notifier.sv
timesync_stamper.sv
daq_arbiter.sv
daq_top.sv
tb_daq_top.sv

//--- tb_daq_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_daq_top;

	localparam logic [7:0] TYPE_SET = 8'd32;
	localparam logic [7:0] TYPE_ROLLOVER = 8'd33;
	localparam logic [7:0] TYPE_TIMESYNC = 8'd34;
	localparam int OP_SET = 0;
	localparam int OP_SYNC = 1;
	localparam int OP_BOTH = 2;
	localparam int OP_WAIT = 3;
	localparam int MAX_CMDS = 64;

	logic clk = 1'b0;
	logic rst_n;
	logic [63:0] systime_set;
	logic systime_set_en;
	logic timesync;
	logic [63:0] systime;
	logic [7:0] leds;
	daq_pkg::daq_beat_t daq_beat;
	logic daq_valid;

	int cmd_op [MAX_CMDS];
	logic [63:0] cmd_arg [MAX_CMDS];
	int n_cmds = 0;
	int idx;
	int gap;
	int seed_ret;
	int cycle_count = 0;
	int cycle_limit = 0;
	int error_count = 0;
	int check_count = 0;
	logic file_ok;
	logic [63:0] model_time = '0;
	logic [7:0] model_leds = 8'h01;
	logic model_live = 1'b0;
	logic [7:0] prev_leds = 8'h01;
	logic have_upper = 1'b0;
	logic [31:0] upper_word;
	logic [63:0] notif_q [$]; // type code above the 56 stamped time bits.
	logic [55:0] stamp_q [$]; // earliest allowed timesync stamp.

	daq_top #(
		.ROLLOVER_BITS(8),
		.HEARTBEAT_BITS(5)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.timesync(timesync),
		.systime(systime),
		.leds(leds),
		.daq_beat(daq_beat),
		.daq_valid(daq_valid)
	);

	always #20 clk = ~clk;

	task automatic flag_error(input string msg);
		error_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic load_commands(output logic ok);
		int fd;
		int r;
		int wait_sum;
		logic [63:0] word;
		logic [8*128-1:0] rest;
		logic [63:0] value;
		ok = 1'b0;
		wait_sum = 0;
		fd = $fopen("daq_stimulus.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			word = '0;
			r = $fscanf(fd, "%s", word);
			while (r == 1 && n_cmds < MAX_CMDS) begin
				if (word == "#") begin
					r = $fgets(rest, fd); // rest of a comment line.
				end else if (word == "SYNC") begin
					cmd_op[n_cmds] = OP_SYNC;
					cmd_arg[n_cmds] = '0;
					n_cmds++;
				end else if (word == "SET" || word == "BOTH" || word == "WAIT") begin
					value = '0;
					r = $fscanf(fd, "%h", value);
					cmd_op[n_cmds] = (word == "SET") ? OP_SET :
						(word == "BOTH") ? OP_BOTH : OP_WAIT;
					cmd_arg[n_cmds] = value;
					if (word == "WAIT") begin
						wait_sum += int'(value);
					end
					n_cmds++;
				end else begin
					$display("unknown command in the stimulus file, it is skipped");
					error_count++;
				end
				word = '0;
				r = $fscanf(fd, "%s", word);
			end
			$fclose(fd);
		end
		cycle_limit = wait_sum + 100 * n_cmds;
	endtask

	task automatic check_load(input logic [63:0] value);
		check_count++;
		if (systime !== value) begin
			flag_error($sformatf("systime %h one cycle after set, expected %h", systime, value));
		end
	endtask

	// sets stay clear of a rollover packet so the set packet carries the set value.
	task automatic wait_for_quiet_time();
		while (model_time[7:0] < 8'h10 || model_time[7:0] > 8'hc0) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_set(input logic [63:0] value);
		systime_set = value;
		systime_set_en = 1'b1;
		notif_q.push_back({TYPE_SET, value[55:0]});
		@(negedge clk);
		systime_set_en = 1'b0;
		check_load(value);
	endtask

	task automatic pulse_timesync(input logic with_set, input logic [63:0] value);
		timesync = 1'b1;
		if (with_set) begin
			systime_set = value;
			systime_set_en = 1'b1;
			notif_q.push_back({TYPE_SET, value[55:0]});
		end
		@(negedge clk);
		systime_set_en = 1'b0;
		if (with_set) begin
			check_load(value);
		end
		@(negedge clk);
		timesync = 1'b0;
		stamp_q.push_back(model_time[55:0]); // two cycles after the pulse began.
	endtask

	task automatic check_packet(input logic [31:0] upper, input logic [31:0] lower);
		logic [7:0] ptype;
		logic [55:0] ptime;
		logic [55:0] lo;
		logic [63:0] expected;
		ptype = upper[31:24];
		ptime = {upper[23:0], lower};
		check_count++;
		if (ptype == TYPE_TIMESYNC) begin
			if (stamp_q.size() == 0) begin
				flag_error($sformatf("timesync packet at %h with none expected", ptime));
			end else begin
				lo = stamp_q.pop_front();
				if (ptime - lo > 56'd2) begin
					flag_error($sformatf("timesync stamp %h, expected %h to %h",
						ptime, lo, lo + 2));
				end
			end
		end else if (ptype == TYPE_SET || ptype == TYPE_ROLLOVER) begin
			if (notif_q.size() == 0) begin
				flag_error($sformatf("packet type %0d at %h with none expected", ptype, ptime));
			end else begin
				expected = notif_q.pop_front();
				if (ptype != expected[63:56] || ptime != expected[55:0]) begin
					flag_error($sformatf("packet type %0d time %h, expected type %0d time %h",
						ptype, ptime, expected[63:56], expected[55:0]));
				end
				if (ptype == TYPE_ROLLOVER && ptime[7:0] != 8'h00) begin
					flag_error($sformatf("rollover packet time %h has low bits set", ptime));
				end
			end
		end else begin
			flag_error($sformatf("packet with unknown type %0d", ptype));
		end
	endtask

	task automatic take_beat(input daq_pkg::daq_beat_t beat);
		if (!beat.last) begin
			if (have_upper) begin
				flag_error("upper beat arrived while another packet was open");
			end
			upper_word = beat.data;
			have_upper = 1'b1;
		end else if (!have_upper) begin
			flag_error("last beat arrived without an upper beat");
		end else begin
			check_packet(upper_word, beat.data);
			have_upper = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			model_time = '0;
			model_leds = 8'h01;
		end else begin
			model_live = 1'b1;
			if (model_time[4:0] == 5'd0) begin
				model_leds = {model_leds[6:0], model_leds[7]}; // low time bits are at zero.
			end
			if (systime_set_en) begin
				model_time = systime_set;
			end else begin
				if (model_time[7:0] == 8'hff) begin
					notif_q.push_back({TYPE_ROLLOVER, model_time[55:0] + 56'd1});
				end
				model_time = model_time + 64'd1;
			end
		end
	end

	always @(negedge clk) begin
		if (model_live) begin
			check_count++;
			if (systime !== model_time) begin
				flag_error($sformatf("systime %h, expected %h", systime, model_time));
			end
			if (leds == 8'h00 || (leds & (leds - 8'h01)) != 8'h00) begin
				flag_error($sformatf("leds %b not one-hot", leds));
			end else if (leds != prev_leds && leds != {prev_leds[6:0], prev_leds[7]}) begin
				flag_error($sformatf("leds moved from %b to %b", prev_leds, leds));
			end
			if (leds !== model_leds) begin
				flag_error($sformatf("leds %b, expected %b", leds, model_leds));
			end
			prev_leds = leds;
			if (daq_valid) begin
				take_beat(daq_beat);
			end else if (have_upper) begin
				flag_error("packet broken off after its upper beat");
				have_upper = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("checks: %0d, errors: %0d", check_count, error_count);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		systime_set = '0;
		systime_set_en = 1'b0;
		timesync = 1'b0;
		seed_ret = $urandom(30);
		load_commands(file_ok);
		if (!file_ok) begin
			$display("the stimulus file could not be opened, nothing was run");
			$display("Errors found");
			$finish;
		end else begin
			repeat (8) @(negedge clk);
			rst_n = 1'b1;
			check_count++;
			if (leds !== 8'h01 || daq_valid !== 1'b0) begin
				flag_error($sformatf("after reset leds %b daq_valid %b", leds, daq_valid));
			end
			for (idx = 0; idx < n_cmds; idx++) begin
				case (cmd_op[idx])
				OP_SET: begin
					wait_for_quiet_time();
					apply_set(cmd_arg[idx]);
				end
				OP_SYNC: begin
					pulse_timesync(1'b0, '0);
				end
				OP_BOTH: begin
					wait_for_quiet_time();
					pulse_timesync(1'b1, cmd_arg[idx]);
				end
				default: begin
					repeat (int'(cmd_arg[idx])) @(negedge clk);
				end
				endcase
				gap = $urandom % 4;
				repeat (gap) @(negedge clk);
			end
			while (notif_q.size() != 0 || stamp_q.size() != 0 || have_upper) begin
				@(negedge clk);
				#1; // the monitor has taken this edge's beat.
			end
			$display("checks: %0d, errors: %0d", check_count, error_count);
			if (error_count == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- daq_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "daq_macros.svh"

module daq_top #(
	parameter int ROLLOVER_BITS = `DAQ_ROLLOVER_BITS,
	parameter int HEARTBEAT_BITS = `DAQ_HEARTBEAT_BITS
) (
	input wire clk,
	input wire rst_n,
	input wire [`DAQ_TIME_BITS-1:0] systime_set,
	input wire systime_set_en,
	input wire timesync,
	output logic [`DAQ_TIME_BITS-1:0] systime,
	output logic [`DAQ_NUM_LEDS-1:0] leds,
	output daq_pkg::daq_beat_t daq_beat,
	output logic daq_valid
);

	logic rollover;
	logic [1:0] req;
	logic [1:0] grant;
	logic [1:0] src_valid;
	daq_pkg::daq_beat_t [1:0] src_beat; // source 0 is the notifier, 1 the stamper.

	timebase #(
		.ROLLOVER_BITS(ROLLOVER_BITS),
		.HEARTBEAT_BITS(HEARTBEAT_BITS)
	) u_timebase (
		.clk(clk),
		.rst_n(rst_n),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime),
		.rollover(rollover),
		.leds(leds)
	);

	systime_notifier u_systime_notifier (
		.clk(clk),
		.rst_n(rst_n),
		.systime(systime),
		.systime_set_en(systime_set_en),
		.rollover(rollover),
		.req(req[0]),
		.grant(grant[0]),
		.beat(src_beat[0]),
		.beat_valid(src_valid[0])
	);

	timesync_stamper u_timesync_stamper (
		.clk(clk),
		.rst_n(rst_n),
		.systime(systime),
		.timesync(timesync),
		.req(req[1]),
		.grant(grant[1]),
		.beat(src_beat[1]),
		.beat_valid(src_valid[1])
	);

	daq_arbiter u_daq_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.grant(grant),
		.src_beat(src_beat),
		.src_valid(src_valid),
		.daq_beat(daq_beat),
		.daq_valid(daq_valid)
	);

endmodule

`default_nettype wire

//--- daq_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "daq_macros.svh"

module daq_arbiter (
	input wire clk,
	input wire rst_n,
	input wire [1:0] req,
	output logic [1:0] grant,
	input wire daq_pkg::daq_beat_t [1:0] src_beat,
	input wire [1:0] src_valid,
	output daq_pkg::daq_beat_t daq_beat,
	output logic daq_valid
);

	daq_pkg::arb_state_e state;
	logic owner; // holds the outlet while busy, and is the last one served after.
	logic pick;

	// on a tie the source that was not served last wins.
	always_comb begin
		pick = ~owner;
		if (req == 2'b01) begin
			pick = 1'b0;
		end else if (req == 2'b10) begin
			pick = 1'b1;
		end
		grant = 2'b00;
		if (state == daq_pkg::FREE && req != 2'b00) begin
			grant[pick] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= daq_pkg::FREE;
			owner <= 1'b1;
			daq_valid <= 1'b0;
		end else begin
			daq_valid <= 1'b0;
			case (state)
			daq_pkg::FREE: begin
				if (grant != 2'b00) begin
					state <= daq_pkg::BUSY;
					owner <= pick;
				end
			end
			default: begin
				if (src_valid[owner]) begin
					daq_valid <= 1'b1;
					if (src_beat[owner].last) begin
						state <= daq_pkg::FREE;
					end
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == daq_pkg::BUSY && src_valid[owner]) begin
			daq_beat <= src_beat[owner];
		end
	end

	grant_one_hot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(grant)
	) else $error("more than one DAQ grant");

	no_grant_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		grant != 2'b00 |-> state == daq_pkg::FREE
	) else $error("DAQ grant while the outlet is busy");

	// only the owner may send, and only while it holds the outlet.
	valid_from_owner: assert property (
		@(posedge clk) disable iff (!rst_n)
		src_valid != 2'b00 |-> state == daq_pkg::BUSY && src_valid == (2'b01 << owner)
	) else $error("DAQ beat from a source that does not own the outlet");

endmodule

`default_nettype wire

//--- timesync_stamper.sv
`timescale 1ns/10ps
`default_nettype none

`include "daq_macros.svh"

module timesync_stamper (
	input wire clk,
	input wire rst_n,
	input wire [`DAQ_TIME_BITS-1:0] systime,
	input wire timesync,
	output logic req,
	input wire grant,
	output daq_pkg::daq_beat_t beat,
	output logic beat_valid
);

	daq_pkg::src_state_e state;
	logic [1:0] sync;
	logic sync_prev;
	logic rise;
	logic pending;
	logic take;
	logic [`DAQ_STAMP_BITS-1:0] stamp_time;
	logic [`DAQ_STAMP_BITS-1:0] pkt_time;

	assign rise = sync[1] & ~sync_prev;
	assign take = (state == daq_pkg::IDLE) && pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b00;
			sync_prev <= 1'b0;
		end else begin
			sync <= {sync[0], timesync}; // timesync is asynchronous to clk.
			sync_prev <= sync[1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else begin
			if (take) begin
				pending <= 1'b0;
			end
			if (rise) begin
				pending <= 1'b1;
			end
		end
	end

	// the first held edge keeps its stamp and further edges only keep pending set.
	always_ff @(posedge clk) begin
		if (rise && (!pending || take)) begin
			stamp_time <= systime[`DAQ_STAMP_BITS-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= daq_pkg::IDLE;
			req <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			case (state)
			daq_pkg::IDLE: begin
				if (pending) begin
					req <= 1'b1;
					state <= daq_pkg::WAIT_GRANT;
				end
			end
			daq_pkg::WAIT_GRANT: begin
				if (grant) begin
					req <= 1'b0;
					beat_valid <= 1'b1;
					state <= daq_pkg::SEND_UPPER;
				end
			end
			daq_pkg::SEND_UPPER: begin
				state <= daq_pkg::SEND_LOWER;
			end
			default: begin
				beat_valid <= 1'b0;
				state <= daq_pkg::IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pkt_time <= stamp_time;
		end
		if (state == daq_pkg::WAIT_GRANT && grant) begin
			beat.data <= {daq_pkg::TIMESYNC_LATCH, pkt_time[`DAQ_STAMP_BITS-1:`DAQ_WORD_BITS]};
			beat.last <= 1'b0;
		end else if (state == daq_pkg::SEND_UPPER) begin
			beat.data <= pkt_time[`DAQ_WORD_BITS-1:0];
			beat.last <= 1'b1;
		end
	end

	grant_on_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		grant |-> req
	) else $error("timesync stamper granted without a request");

endmodule

`default_nettype wire

//--- systime_notifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "daq_macros.svh"

module systime_notifier (
	input wire clk,
	input wire rst_n,
	input wire [`DAQ_TIME_BITS-1:0] systime,
	input wire systime_set_en,
	input wire rollover,
	output logic req,
	input wire grant,
	output daq_pkg::daq_beat_t beat,
	output logic beat_valid
);

	daq_pkg::src_state_e state;
	daq_pkg::daq_type_e pend_type;
	daq_pkg::daq_type_e pkt_type;
	logic pending;
	logic take;
	logic [`DAQ_STAMP_BITS-1:0] pkt_time;

	assign take = (state == daq_pkg::IDLE) && pending;

	// a set beats a rollover in the same cycle, later triggers overwrite the type.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			pend_type <= daq_pkg::SYSTIME_SET;
		end else begin
			if (take) begin
				pending <= 1'b0;
			end
			if (systime_set_en) begin
				pending <= 1'b1;
				pend_type <= daq_pkg::SYSTIME_SET;
			end else if (rollover) begin
				pending <= 1'b1;
				pend_type <= daq_pkg::SYSTIME_ROLLOVER;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= daq_pkg::IDLE;
			req <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			case (state)
			daq_pkg::IDLE: begin
				if (pending) begin
					req <= 1'b1;
					state <= daq_pkg::WAIT_GRANT;
				end
			end
			daq_pkg::WAIT_GRANT: begin
				if (grant) begin
					req <= 1'b0;
					beat_valid <= 1'b1;
					state <= daq_pkg::SEND_UPPER;
				end
			end
			daq_pkg::SEND_UPPER: begin
				state <= daq_pkg::SEND_LOWER;
			end
			default: begin
				beat_valid <= 1'b0;
				state <= daq_pkg::IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pkt_time <= systime[`DAQ_STAMP_BITS-1:0]; // the set value or a fresh wrap.
			pkt_type <= pend_type;
		end
		if (state == daq_pkg::WAIT_GRANT && grant) begin
			beat.data <= {pkt_type, pkt_time[`DAQ_STAMP_BITS-1:`DAQ_WORD_BITS]};
			beat.last <= 1'b0;
		end else if (state == daq_pkg::SEND_UPPER) begin
			beat.data <= pkt_time[`DAQ_WORD_BITS-1:0];
			beat.last <= 1'b1;
		end
	end

	// beats only leave while the packet is being sent.
	valid_in_send: assert property (
		@(posedge clk) disable iff (!rst_n)
		beat_valid |-> (state == daq_pkg::SEND_UPPER || state == daq_pkg::SEND_LOWER)
	) else $error("systime beat outside a send state");

	// the arbiter only grants a raised request.
	grant_on_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		grant |-> req
	) else $error("systime notifier granted without a request");

endmodule

`default_nettype wire

//--- timebase.sv
`timescale 1ns/10ps
`default_nettype none

`include "daq_macros.svh"

module timebase #(
	parameter int ROLLOVER_BITS = `DAQ_ROLLOVER_BITS,
	parameter int HEARTBEAT_BITS = `DAQ_HEARTBEAT_BITS
) (
	input wire clk,
	input wire rst_n,
	input wire [`DAQ_TIME_BITS-1:0] systime_set,
	input wire systime_set_en,
	output logic [`DAQ_TIME_BITS-1:0] systime,
	output logic rollover,
	output logic [`DAQ_NUM_LEDS-1:0] leds
);

	logic heartbeat;

	assign rollover = &systime[ROLLOVER_BITS-1:0]; // next cycle wraps the low bits.
	assign heartbeat = (systime[HEARTBEAT_BITS-1:0] == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			systime <= '0;
		end else if (systime_set_en) begin
			systime <= systime_set;
		end else begin
			systime <= systime + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds <= {{(`DAQ_NUM_LEDS-1){1'b0}}, 1'b1};
		end else if (heartbeat) begin
			leds <= {leds[`DAQ_NUM_LEDS-2:0], leds[`DAQ_NUM_LEDS-1]}; // rotate left.
		end
	end

endmodule

`default_nettype wire

//--- daq_pkg.sv
`default_nettype none

`include "daq_macros.svh"

package daq_pkg;

	typedef enum logic [`DAQ_TYPE_BITS-1:0] {
		SYSTIME_SET = `DAQ_TYPE_SYSTIME_SET,
		SYSTIME_ROLLOVER = `DAQ_TYPE_SYSTIME_ROLLOVER,
		TIMESYNC_LATCH = `DAQ_TYPE_TIMESYNC_LATCH
	} daq_type_e;

	// one data beat on a DAQ link, last marks the closing word of a packet.
	typedef struct packed {
		logic [`DAQ_WORD_BITS-1:0] data;
		logic last;
	} daq_beat_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_GRANT,
		SEND_UPPER,
		SEND_LOWER
	} src_state_e;

	typedef enum logic {
		FREE,
		BUSY
	} arb_state_e;

endpackage

`default_nettype wire

//--- daq_macros.svh
`ifndef DAQ_MACROS_SVH
`define DAQ_MACROS_SVH

// system time and DAQ word widths.
`define DAQ_TIME_BITS 64
`define DAQ_WORD_BITS 32
`define DAQ_TYPE_BITS 8

// time bits carried in a packet, below the type code.
`define DAQ_STAMP_BITS (`DAQ_TIME_BITS - `DAQ_TYPE_BITS)

// packet type codes.
`define DAQ_TYPE_SYSTIME_SET 8'd32
`define DAQ_TYPE_SYSTIME_ROLLOVER 8'd33
`define DAQ_TYPE_TIMESYNC_LATCH 8'd34

// default bit counts for the rollover and heartbeat wraps.
`define DAQ_ROLLOVER_BITS 26
`define DAQ_HEARTBEAT_BITS 22

`define DAQ_NUM_LEDS 8

`endif
